/* src/lsu_defs.svh */
`ifndef LSU_DEFS_SVH
`define LSU_DEFS_SVH

// Data and address width, one RV32 word
`define LSU_XLEN 32

// Word-address bits of the data RAM, 256 words by default
`define LSU_RAM_AW 8

// RV32I load/store funct3 codes
// Byte access, signed on loads
`define LSU_F3_B  3'd0
// Half access, signed on loads
`define LSU_F3_H  3'd1
// Full word
`define LSU_F3_W  3'd2
// Unsigned byte load
`define LSU_F3_BU 3'd4
// Unsigned half load
`define LSU_F3_HU 3'd5

`endif

/* src/lsu_pkg.sv */
`include "lsu_defs.svh"

package lsu_pkg;

  // Memory operation presented by the core
  typedef enum logic [1:0] {
    LSU_OP_NONE  = 2'd0,
    LSU_OP_LOAD  = 2'd1,
    LSU_OP_STORE = 2'd2
  } lsu_op_e;

  // One bus word, seen as byte lanes or as half lanes
  // Lane 0 is the least significant byte (little endian)
  typedef union packed {
    logic [(`LSU_XLEN/8)-1:0][7:0]   b;
    logic [(`LSU_XLEN/16)-1:0][15:0] h;
  } mem_word_u;

endpackage

/* src/lsu_load_align.sv */
`timescale 1ns/1ps
`include "lsu_defs.svh"

module lsu_load_align
  import lsu_pkg::*;
(
  input  logic [1:0]           off_i,
  input  logic [2:0]           funct3_i,
  input  logic [`LSU_XLEN-1:0] rdata_i,
  output logic [`LSU_XLEN-1:0] load_o
);

  // Returned word, decoded through both lane views
  mem_word_u   rword;
  logic [7:0]  byte_sel;
  logic [15:0] half_sel;

  assign rword = rdata_i;

  // Byte chosen by both offset bits
  assign byte_sel = rword.b[off_i];
  // Half chosen by offset bit 1 only, bit 0 is zero when aligned
  assign half_sel = rword.h[off_i[1]];

  always_comb begin
    case (funct3_i)
      // lb
      `LSU_F3_B: begin
        load_o = {{(`LSU_XLEN-8){byte_sel[7]}}, byte_sel};
      end
      // lh
      `LSU_F3_H: begin
        load_o = {{(`LSU_XLEN-16){half_sel[15]}}, half_sel};
      end
      // lw, whole word unchanged
      `LSU_F3_W: begin
        load_o = rdata_i;
      end
      // lbu
      `LSU_F3_BU: begin
        load_o = {{(`LSU_XLEN-8){1'b0}}, byte_sel};
      end
      // lhu
      `LSU_F3_HU: begin
        load_o = {{(`LSU_XLEN-16){1'b0}}, half_sel};
      end
      // Undefined codes read as zero
      default: begin
        load_o = '0;
      end
    endcase
  end

endmodule

/* src/lsu_store_align.sv */
`timescale 1ns/1ps
`include "lsu_defs.svh"

module lsu_store_align
  import lsu_pkg::*;
(
  input  logic [1:0]           off_i,
  input  logic [2:0]           funct3_i,
  input  logic [`LSU_XLEN-1:0] sdata_i,
  output logic [`LSU_XLEN-1:0] wdata_o,
  output logic [3:0]           sel_o
);

  // Outgoing word, built lane by lane
  mem_word_u wword;

  always_comb begin
    case (funct3_i)
      // Low byte copied onto every lane, one lane enabled
      `LSU_F3_B, `LSU_F3_BU: begin
        for (int i = 0; i < 4; i++) begin
          wword.b[i] = sdata_i[7:0];
        end
        sel_o = 4'b0001 << off_i;
      end
      // Low half copied onto both halves
      `LSU_F3_H, `LSU_F3_HU: begin
        wword.h[0] = sdata_i[15:0];
        wword.h[1] = sdata_i[15:0];
        // Upper or lower pair of lanes
        sel_o = off_i[1] ? 4'b1100 : 4'b0011;
      end
      // Full word, all lanes
      `LSU_F3_W: begin
        wword = sdata_i;
        sel_o = 4'b1111;
      end
      // No lanes for undefined codes
      default: begin
        wword = sdata_i;
        sel_o = 4'b0000;
      end
    endcase
  end

  assign wdata_o = wword;

endmodule

/* src/lsu_wb_master.sv */
`timescale 1ns/1ps
`include "lsu_defs.svh"

module lsu_wb_master
  import lsu_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst_n,
  // Core request
  input  logic                   valid_i,
  input  lsu_op_e                op_i,
  input  logic [2:0]             funct3_i,
  input  logic [`LSU_XLEN-1:0]   src1_i,
  input  logic [`LSU_XLEN-1:0]   src2_i,
  input  logic [`LSU_XLEN-1:0]   imm_i,
  // Core response
  output logic                   busy_o,
  output logic                   done_o,
  output logic                   rd_wen_o,
  output logic [`LSU_XLEN-1:0]   result_o,
  output logic                   misalign_o,
  // To both aligners
  output logic [1:0]             off_o,
  output logic [2:0]             funct3_o,
  output logic [`LSU_XLEN-1:0]   sdata_o,
  // From the aligners
  input  logic [`LSU_XLEN-1:0]   wdata_i,
  input  logic [3:0]             sel_i,
  input  logic [`LSU_XLEN-1:0]   load_i,
  // Wishbone classic initiator
  output logic                   wb_cyc_o,
  output logic                   wb_stb_o,
  output logic                   wb_we_o,
  output logic [`LSU_RAM_AW-1:0] wb_adr_o,
  output logic [`LSU_XLEN-1:0]   wb_dat_o,
  output logic [3:0]             wb_sel_o,
  input  logic                   wb_ack_i
);

  // FSM encoding
  localparam logic [1:0] ST_IDLE = 2'd0;
  localparam logic [1:0] ST_BUS  = 2'd1;
  localparam logic [1:0] ST_DONE = 2'd2;

  logic [1:0]             state_q;
  lsu_op_e                op_q;
  logic                   misalign_q;
  logic [`LSU_XLEN-1:0]   result_q;
  // Latched request payload
  logic [`LSU_RAM_AW-1:0] adr_q;
  logic [1:0]             off_q;
  logic [2:0]             f3_q;
  logic [`LSU_XLEN-1:0]   sdata_q;

  logic [`LSU_XLEN-1:0]   ea;
  logic                   accept;
  logic                   misalign_d;
  logic                   bus_req;

  // Effective address as base plus immediate
  assign ea = src1_i + imm_i;

  // Accepted only when not already in a bus phase
  assign accept = valid_i && (op_i != LSU_OP_NONE) && !busy_o;

  // Alignment judged once from the incoming request
  always_comb begin
    case (funct3_i)
      `LSU_F3_H, `LSU_F3_HU: misalign_d = ea[0];
      `LSU_F3_W:             misalign_d = (ea[1:0] != 2'b00);
      default:               misalign_d = 1'b0;
    endcase
  end

  // Control state
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q    <= ST_IDLE;
      op_q       <= LSU_OP_NONE;
      misalign_q <= 1'b0;
    end else begin
      case (state_q)
        // Misaligned requests skip the bus and finish next edge
        ST_BUS: begin
          if (misalign_q || wb_ack_i) begin
            state_q <= ST_DONE;
          end
        end
        // A new request may follow straight out of DONE
        ST_IDLE, ST_DONE: begin
          if (accept) begin
            state_q    <= ST_BUS;
            op_q       <= op_i;
            misalign_q <= misalign_d;
          end else begin
            state_q <= ST_IDLE;
          end
        end
        default: begin
          state_q <= ST_IDLE;
        end
      endcase
    end
  end

  // Load result captured on the acknowledge of a read
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      result_q <= '0;
    end else if ((state_q == ST_BUS) && wb_ack_i && (op_q == LSU_OP_LOAD)) begin
      result_q <= load_i;
    end
  end

  // Own copy of the request so the core may move on
  always_ff @(posedge clk) begin
    if (accept) begin
      // Only word-address bits kept so addresses wrap on the RAM size
      adr_q   <= ea[`LSU_RAM_AW+1:2];
      off_q   <= ea[1:0];
      f3_q    <= funct3_i;
      sdata_q <= src2_i;
    end
  end

  // Core side
  assign busy_o     = (state_q == ST_BUS);
  assign done_o     = (state_q == ST_DONE);
  assign misalign_o = done_o && misalign_q;
  assign rd_wen_o   = done_o && !misalign_q && (op_q == LSU_OP_LOAD);
  assign result_o   = result_q;

  // Aligner side
  assign off_o    = off_q;
  assign funct3_o = f3_q;
  assign sdata_o  = sdata_q;

  // Bus cycle only for aligned requests
  assign bus_req  = busy_o && !misalign_q;
  assign wb_cyc_o = bus_req;
  assign wb_stb_o = bus_req;
  assign wb_we_o  = bus_req && (op_q == LSU_OP_STORE);
  assign wb_adr_o = adr_q;
  assign wb_dat_o = wdata_i;
  assign wb_sel_o = sel_i;

  // Cycle and strobe end together in the cycle after ack
  a_cyc_drop: assert property (@(posedge clk) disable iff (!rst_n)
    wb_ack_i |=> (!wb_cyc_o && !wb_stb_o));

  // Request held steady until the target acknowledges
  a_bus_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (wb_stb_o && !wb_ack_i) |=>
      (wb_stb_o && $stable(wb_we_o) && $stable(wb_adr_o) &&
       $stable(wb_dat_o) && $stable(wb_sel_o)));

  // Completion always closes a stall cycle
  a_done_after_busy: assert property (@(posedge clk) disable iff (!rst_n)
    done_o |-> $past(busy_o));

endmodule

/* src/lsu_data_ram.sv */
`timescale 1ns/1ps
`include "lsu_defs.svh"

module lsu_data_ram #(
  parameter int AW = `LSU_RAM_AW
) (
  input  logic                 clk,
  input  logic                 rst_n,
  // Wishbone classic target
  input  logic                 wb_cyc_i,
  input  logic                 wb_stb_i,
  input  logic                 wb_we_i,
  input  logic [AW-1:0]        wb_adr_i,
  input  logic [`LSU_XLEN-1:0] wb_dat_i,
  input  logic [3:0]           wb_sel_i,
  output logic                 wb_ack_o,
  output logic [`LSU_XLEN-1:0] wb_dat_o
);

  // Storage of 2**AW words
  logic [`LSU_XLEN-1:0] mem_q [0:(2**AW)-1];
  logic [`LSU_XLEN-1:0] dat_q;
  logic                 ack_q;
  logic                 req;

  // New request not yet acknowledged
  assign req = wb_cyc_i && wb_stb_i && !ack_q;

  // Single-cycle ack dropped right after it is given
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= req;
    end
  end

  // Lane writes and read capture on the edge that raises ack
  always_ff @(posedge clk) begin
    if (req) begin
      if (wb_we_i) begin
        for (int i = 0; i < 4; i++) begin
          if (wb_sel_i[i]) begin
            mem_q[wb_adr_i][i*8 +: 8] <= wb_dat_i[i*8 +: 8];
          end
        end
      end
      // Old word also returned on a write and ignored by the master
      dat_q <= mem_q[wb_adr_i];
    end
  end

  assign wb_ack_o = ack_q;
  assign wb_dat_o = dat_q;

  // Ack only answers a strobe the master still holds
  a_ack_follows_req: assert property (@(posedge clk) disable iff (!rst_n)
    wb_ack_o |-> (wb_cyc_i && wb_stb_i));

endmodule

/* src/lsu_subsys.sv */
`timescale 1ns/1ps
`include "lsu_defs.svh"

module lsu_subsys
  import lsu_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst_n,
  // Core request
  input  logic                 valid_i,
  input  lsu_op_e              op_i,
  input  logic [2:0]           funct3_i,
  input  logic [`LSU_XLEN-1:0] src1_i,
  input  logic [`LSU_XLEN-1:0] src2_i,
  input  logic [`LSU_XLEN-1:0] imm_i,
  // Core response
  output logic                 busy_o,
  output logic                 done_o,
  output logic                 rd_wen_o,
  output logic [`LSU_XLEN-1:0] result_o,
  output logic                 misalign_o
);

  // Master to aligners
  logic [1:0]             off;
  logic [2:0]             funct3;
  logic [`LSU_XLEN-1:0]   sdata;
  // Aligners to master
  logic [`LSU_XLEN-1:0]   wdata;
  logic [3:0]             sel;
  logic [`LSU_XLEN-1:0]   load;
  // Wishbone
  logic                   wb_cyc;
  logic                   wb_stb;
  logic                   wb_we;
  logic [`LSU_RAM_AW-1:0] wb_adr;
  logic [`LSU_XLEN-1:0]   wb_dat_w;
  logic [`LSU_XLEN-1:0]   wb_dat_r;
  logic [3:0]             wb_sel;
  logic                   wb_ack;

  lsu_wb_master u_master (
    .clk        (clk),
    .rst_n      (rst_n),
    .valid_i    (valid_i),
    .op_i       (op_i),
    .funct3_i   (funct3_i),
    .src1_i     (src1_i),
    .src2_i     (src2_i),
    .imm_i      (imm_i),
    .busy_o     (busy_o),
    .done_o     (done_o),
    .rd_wen_o   (rd_wen_o),
    .result_o   (result_o),
    .misalign_o (misalign_o),
    .off_o      (off),
    .funct3_o   (funct3),
    .sdata_o    (sdata),
    .wdata_i    (wdata),
    .sel_i      (sel),
    .load_i     (load),
    .wb_cyc_o   (wb_cyc),
    .wb_stb_o   (wb_stb),
    .wb_we_o    (wb_we),
    .wb_adr_o   (wb_adr),
    .wb_dat_o   (wb_dat_w),
    .wb_sel_o   (wb_sel),
    .wb_ack_i   (wb_ack)
  );

  // Read path, bus word to register value
  lsu_load_align u_load_align (
    .off_i    (off),
    .funct3_i (funct3),
    .rdata_i  (wb_dat_r),
    .load_o   (load)
  );

  // Write path, register value to lanes
  lsu_store_align u_store_align (
    .off_i    (off),
    .funct3_i (funct3),
    .sdata_i  (sdata),
    .wdata_o  (wdata),
    .sel_o    (sel)
  );

  lsu_data_ram #(
    .AW (`LSU_RAM_AW)
  ) u_ram (
    .clk      (clk),
    .rst_n    (rst_n),
    .wb_cyc_i (wb_cyc),
    .wb_stb_i (wb_stb),
    .wb_we_i  (wb_we),
    .wb_adr_i (wb_adr),
    .wb_dat_i (wb_dat_w),
    .wb_sel_i (wb_sel),
    .wb_ack_o (wb_ack),
    .wb_dat_o (wb_dat_r)
  );

endmodule

/* sim/lsu_tb.sv */
`timescale 1ns/1ps
`include "lsu_defs.svh"

module lsu_tb
  import lsu_pkg::*;
();

  localparam int N_RANDOM    = 300;
  // Directed operations of the fill, round trip, lane, extension, misaligned and chain tests
  localparam int N_DIRECTED  = 256 + 32 + 8 + 26 + 11 + 8;
  localparam int N_OPS       = N_DIRECTED + N_RANDOM;
  // At most 20 cycles of 10 ns per operation plus a margin
  localparam int WATCHDOG_NS = (N_OPS * 20 + 200) * 10;

  logic                 clk;
  logic                 rst_n;
  logic                 valid_i;
  lsu_op_e              op_i;
  logic [2:0]           funct3_i;
  logic [`LSU_XLEN-1:0] src1_i;
  logic [`LSU_XLEN-1:0] src2_i;
  logic [`LSU_XLEN-1:0] imm_i;
  logic                 busy_o;
  logic                 done_o;
  logic                 rd_wen_o;
  logic [`LSU_XLEN-1:0] result_o;
  logic                 misalign_o;

  // Byte model of the 1 KiB RAM
  logic [7:0]  model_mem [0:1023];
  logic [31:0] rng_q;
  // Expected response of the request in flight
  logic [31:0] exp_result;
  logic [31:0] last_load;
  logic        exp_rd_wen;
  logic        exp_misalign;
  int          exp_lat;
  int          pass_cnt;
  int          fail_cnt;

  lsu_subsys dut_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .valid_i    (valid_i),
    .op_i       (op_i),
    .funct3_i   (funct3_i),
    .src1_i     (src1_i),
    .src2_i     (src2_i),
    .imm_i      (imm_i),
    .busy_o     (busy_o),
    .done_o     (done_o),
    .rd_wen_o   (rd_wen_o),
    .result_o   (result_o),
    .misalign_o (misalign_o)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // LCG step with the Numerical Recipes constants
  function automatic logic [31:0] lcg_next();
    rng_q = rng_q * 32'd1664525 + 32'd1013904223;
    return rng_q;
  endfunction

  // Half needs an even address and word needs offset zero
  function automatic logic is_misaligned(input logic [31:0] ea, input logic [2:0] f3);
    case (f3)
      `LSU_F3_H, `LSU_F3_HU: return ea[0];
      `LSU_F3_W:             return ea[1:0] != 2'b00;
      default:               return 1'b0;
    endcase
  endfunction

  // Expected load value from the little-endian model bytes
  function automatic logic [31:0] exp_load(input logic [31:0] ea, input logic [2:0] f3);
    logic [9:0]  a;
    logic [15:0] half;
    a = ea[9:0];
    half = {model_mem[a + 10'd1], model_mem[a]};
    case (f3)
      `LSU_F3_B:  return {{24{model_mem[a][7]}}, model_mem[a]};
      `LSU_F3_BU: return {24'd0, model_mem[a]};
      `LSU_F3_H:  return {{16{half[15]}}, half};
      `LSU_F3_HU: return {16'd0, half};
      `LSU_F3_W:  return {model_mem[a + 10'd3], model_mem[a + 10'd2], half};
      default:    return 32'd0;
    endcase
  endfunction

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] got);
    if (exp !== got) begin
      $display("Fail %s: expected %h, got %h", name, exp, got);
      fail_cnt++;
    end else begin
      pass_cnt++;
    end
  endtask

  // Sets the expected response and updates the model at acceptance
  task automatic expect_op(input lsu_op_e op, input logic [2:0] f3, input logic [31:0] ea,
                           input logic [31:0] d);
    logic [9:0] a;
    a = ea[9:0];
    exp_misalign = is_misaligned(ea, f3);
    exp_lat      = exp_misalign ? 1 : 2;
    exp_rd_wen   = !exp_misalign && (op == LSU_OP_LOAD);
    if (exp_rd_wen) begin
      last_load = exp_load(ea, f3);
    end else if (!exp_misalign) begin
      // Aligned store changes only the addressed lanes
      model_mem[a] = d[7:0];
      if (f3 != `LSU_F3_B) begin
        model_mem[a + 10'd1] = d[15:8];
      end
      if (f3 == `LSU_F3_W) begin
        model_mem[a + 10'd2] = d[23:16];
        model_mem[a + 10'd3] = d[31:24];
      end
    end
    exp_result = last_load;
  endtask

  task automatic drive_req(input lsu_op_e op, input logic [2:0] f3, input logic [31:0] s1,
                           input logic [31:0] s2, input logic [31:0] imm);
    valid_i  <= 1'b1;
    op_i     <= op;
    funct3_i <= f3;
    src1_i   <= s1;
    src2_i   <= s2;
    imm_i    <= imm;
  endtask

  // Starts at a falling edge and returns just after the accepting edge
  task automatic wait_accept();
    while (busy_o) begin
      @(negedge clk);
    end
    @(posedge clk);
  endtask

  // Counts cycles from acceptance to done_o while the stall must hold
  task automatic wait_done();
    int lat;
    lat = 0;
    @(negedge clk);
    while (!done_o) begin
      if (!busy_o) begin
        $display("busy_o dropped before done_o arrived");
        fail_cnt++;
      end
      lat++;
      @(negedge clk);
    end
    check_val("done_o latency", 32'(exp_lat), 32'(lat));
  endtask

  task automatic issue_op(input lsu_op_e op, input logic [2:0] f3, input logic [31:0] s1,
                          input logic [31:0] s2, input logic [31:0] imm);
    @(posedge clk);
    drive_req(op, f3, s1, s2, imm);
    @(negedge clk);
    wait_accept();
    valid_i <= 1'b0;
    op_i    <= LSU_OP_NONE;
    expect_op(op, f3, s1 + imm, s2);
    wait_done();
    // Pulse must be gone one cycle later
    @(negedge clk);
    if (done_o) begin
      $display("done_o stayed high for more than one cycle");
      fail_cnt++;
    end
  endtask

  // Eight requests with valid_i held high and the next one shown at each acceptance
  task automatic run_chain();
    lsu_op_e     ops  [8];
    logic [2:0]  f3s  [8];
    logic [31:0] offs [8];
    logic [31:0] dats [8];
    logic [31:0] base;
    base = 32'h0000_03C0;
    ops  = '{LSU_OP_STORE, LSU_OP_LOAD, LSU_OP_LOAD, LSU_OP_LOAD,
             LSU_OP_STORE, LSU_OP_STORE, LSU_OP_LOAD, LSU_OP_LOAD};
    f3s  = '{`LSU_F3_W, `LSU_F3_W, `LSU_F3_H, `LSU_F3_BU,
             `LSU_F3_W, `LSU_F3_H, `LSU_F3_W, `LSU_F3_HU};
    // Offsets 1, 6 and 3 on H, W and HU are misaligned
    offs = '{32'd0, 32'd0, 32'd1, 32'd3, 32'd6, 32'd2, 32'd0, 32'd3};
    for (int k = 0; k < 8; k++) begin
      dats[k] = lcg_next();
    end
    @(posedge clk);
    drive_req(ops[0], f3s[0], base, dats[0], offs[0]);
    @(negedge clk);
    for (int k = 0; k < 8; k++) begin
      wait_accept();
      if (k < 7) begin
        drive_req(ops[k+1], f3s[k+1], base, dats[k+1], offs[k+1]);
      end else begin
        valid_i <= 1'b0;
        op_i    <= LSU_OP_NONE;
      end
      expect_op(ops[k], f3s[k], base + offs[k], dats[k]);
      wait_done();
    end
    @(negedge clk);
    if (done_o) begin
      $display("done_o stayed high after the last chained request");
      fail_cnt++;
    end
  endtask

  task automatic report_test(input string name, input int fails_before);
    $display("%s: %0d errors", name, fail_cnt - fails_before);
  endtask

  // Response checker sampled away from the driving edge
  always @(negedge clk) begin
    if (rst_n && done_o) begin
      check_val("rd_wen_o", 32'(exp_rd_wen), 32'(rd_wen_o));
      check_val("misalign_o", 32'(exp_misalign), 32'(misalign_o));
      check_val("result_o", exp_result, result_o);
    end else if (rst_n && (rd_wen_o || misalign_o)) begin
      $display("rd_wen_o or misalign_o went high without done_o");
      fail_cnt++;
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: the DUT stopped completing requests");
    $display("SIMULATION FAILED");
    $finish;
  end

  initial begin
    int          fails_at;
    logic [31:0] r;
    logic [31:0] base;
    logic [31:0] imm;
    lsu_op_e     op;
    logic [2:0]  f3;
    rst_n        = 1'b0;
    valid_i      = 1'b0;
    op_i         = LSU_OP_NONE;
    funct3_i     = 3'd0;
    src1_i       = '0;
    src2_i       = '0;
    imm_i        = '0;
    rng_q        = 32'h2878_7461;
    last_load    = 32'd0;
    exp_result   = 32'd0;
    exp_rd_wen   = 1'b0;
    exp_misalign = 1'b0;
    exp_lat      = 0;
    pass_cnt     = 0;
    fail_cnt     = 0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);

    // Quiet outputs straight after reset
    fails_at = fail_cnt;
    check_val("busy_o", 32'd0, 32'(busy_o));
    check_val("done_o", 32'd0, 32'(done_o));
    check_val("rd_wen_o", 32'd0, 32'(rd_wen_o));
    check_val("result_o", 32'd0, result_o);
    report_test("reset state", fails_at);

    // Whole RAM written first with a pattern built from the word index
    fails_at = fail_cnt;
    for (int w = 0; w < 256; w++) begin
      issue_op(LSU_OP_STORE, `LSU_F3_W, 32'(w) << 2, (32'(w) * 32'h0101_0101) ^ 32'h8040_2A15,
               32'd0);
    end
    report_test("RAM fill", fails_at);

    // Word round trip where odd indices use a negative immediate
    fails_at = fail_cnt;
    for (int k = 0; k < 16; k++) begin
      imm = k[0] ? -(32'(k) * 32'd4) : 32'(k) * 32'd8;
      issue_op(LSU_OP_STORE, `LSU_F3_W, 32'h800 + 32'(k) * 32'd32, lcg_next(), imm);
    end
    for (int k = 0; k < 16; k++) begin
      imm = k[0] ? -(32'(k) * 32'd4) : 32'(k) * 32'd8;
      issue_op(LSU_OP_LOAD, `LSU_F3_W, 32'h800 + 32'(k) * 32'd32, 32'd0, imm);
    end
    report_test("word round trip", fails_at);

    // One sb per lane with the word read back after each
    fails_at = fail_cnt;
    for (int k = 0; k < 4; k++) begin
      issue_op(LSU_OP_STORE, `LSU_F3_B, 32'h3A0, lcg_next(), 32'(k));
      issue_op(LSU_OP_LOAD, `LSU_F3_W, 32'h3A0, 32'd0, 32'd0);
    end
    report_test("byte lanes", fails_at);

    // Mixed top bits in both bytes and halves
    fails_at = fail_cnt;
    for (int p = 0; p < 2; p++) begin
      base = 32'h200 + 32'(p) * 32'd4;
      issue_op(LSU_OP_STORE, `LSU_F3_W, base, p ? 32'h6C91_5EE2 : 32'h8A7B_F305, 32'd0);
      for (int k = 0; k < 4; k++) begin
        issue_op(LSU_OP_LOAD, `LSU_F3_B, base, 32'd0, 32'(k));
        issue_op(LSU_OP_LOAD, `LSU_F3_BU, base, 32'd0, 32'(k));
        if (k[0] == 1'b0) begin
          issue_op(LSU_OP_LOAD, `LSU_F3_H, base, 32'd0, 32'(k));
          issue_op(LSU_OP_LOAD, `LSU_F3_HU, base, 32'd0, 32'(k));
        end
      end
    end
    report_test("sign and zero extension", fails_at);

    // Misaligned requests leave memory and result_o alone
    fails_at = fail_cnt;
    issue_op(LSU_OP_LOAD, `LSU_F3_W, 32'h2C0, 32'd0, 32'd0);
    issue_op(LSU_OP_LOAD, `LSU_F3_H, 32'h2C0, 32'd0, 32'd1);
    issue_op(LSU_OP_LOAD, `LSU_F3_H, 32'h2C0, 32'd0, 32'd3);
    issue_op(LSU_OP_LOAD, `LSU_F3_HU, 32'h2C0, 32'd0, 32'd1);
    for (int k = 1; k < 4; k++) begin
      issue_op(LSU_OP_LOAD, `LSU_F3_W, 32'h2C0, 32'd0, 32'(k));
      issue_op(LSU_OP_STORE, `LSU_F3_W, 32'h2C0, 32'hDEAD_BEEF, 32'(k));
    end
    issue_op(LSU_OP_LOAD, `LSU_F3_W, 32'h2C0, 32'd0, 32'd0);
    report_test("misaligned accesses", fails_at);

    fails_at = fail_cnt;
    run_chain();
    report_test("back-to-back with valid held", fails_at);

    // Random mix with three in four addresses forced aligned
    fails_at = fail_cnt;
    for (int n = 0; n < N_RANDOM; n++) begin
      r    = lcg_next();
      base = lcg_next();
      imm  = {{20{r[23]}}, r[23:12]};
      if (r[3:2] != 2'b00) begin
        base[1:0] = 2'b00;
        imm[1:0]  = 2'b00;
      end
      op = r[0] ? LSU_OP_LOAD : LSU_OP_STORE;
      if (op == LSU_OP_LOAD) begin
        case (int'(r[31:24]) % 5)
          0:       f3 = `LSU_F3_B;
          1:       f3 = `LSU_F3_H;
          2:       f3 = `LSU_F3_W;
          3:       f3 = `LSU_F3_BU;
          default: f3 = `LSU_F3_HU;
        endcase
      end else begin
        f3 = 3'(int'(r[31:24]) % 3);
      end
      issue_op(op, f3, base, lcg_next(), imm);
    end
    report_test("random mix", fails_at);

    $display("Checks passed: %0d, failed: %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

/* all.f */
+incdir+src
src/lsu_pkg.sv
src/lsu_load_align.sv
src/lsu_store_align.sv
src/lsu_wb_master.sv
src/lsu_data_ram.sv
src/lsu_subsys.sv
sim/lsu_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the LSU testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f all.f --top-module lsu_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vlsu_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "SIMULATION FAILED" "$LOG"; then
  exit 1
fi

if ! grep -q "SIMULATION PASSED" "$LOG"; then
  echo "Simulation ended without a result line"
  exit 1
fi

exit 0
